// ==== axil_link_pkg.sv ====
// ==================================================
// Shared widths and the command word layout for the
// AXI4-Lite to register target link. Modules take
// these by a wildcard import in their header.
// ==================================================

package axil_link_pkg;

  // AXI4-Lite side
  localparam int axil_addr_width_c = 32;
  localparam int axil_data_width_c = 32;

  // Command word fields
  localparam int payload_data_width_c = 8;
  localparam int payload_addr_width_c =
    axil_data_width_c - payload_data_width_c - 1;

  // Only OKAY is ever returned on bresp and rresp
  localparam logic [1:0] axi_resp_okay_c = 2'b00;

  // One command word on the link, same layout at both ends
  // Reads carry zero in the data field
  typedef struct packed {
    logic                            write_not_read;
    logic [payload_addr_width_c-1:0] addr;
    logic [payload_data_width_c-1:0] data;
  } cmd_word_s;

endpackage

// ==== axil_store_packer.sv ====
// ==================================================
// AXI4-Lite slave front end. Packs each write or read
// into one command word, one transaction at a time,
// and hands the read byte back on the R channel.
// ==================================================
`timescale 1ns/1ps

module axil_store_packer
  import axil_link_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,

  // Write address
  input  logic [axil_addr_width_c-1:0] s_axil_awaddr_i,
  input  logic                         s_axil_awvalid_i,
  output logic                         s_axil_awready_o,

  // Write data
  input  logic [axil_data_width_c-1:0] s_axil_wdata_i,
  input  logic                         s_axil_wvalid_i,
  output logic                         s_axil_wready_o,

  // Write response
  output logic [1:0]                   s_axil_bresp_o,
  output logic                         s_axil_bvalid_o,
  input  logic                         s_axil_bready_i,

  // Read address
  input  logic [axil_addr_width_c-1:0] s_axil_araddr_i,
  input  logic                         s_axil_arvalid_i,
  output logic                         s_axil_arready_o,

  // Read data
  output logic [axil_data_width_c-1:0] s_axil_rdata_o,
  output logic [1:0]                   s_axil_rresp_o,
  output logic                         s_axil_rvalid_o,
  input  logic                         s_axil_rready_i,

  // Command channel to the credit sender
  output cmd_word_s                    cmd_o,
  output logic                         cmd_v_o,
  input  logic                         cmd_ready_i,

  // Read responses from the target
  input  logic [payload_data_width_c-1:0] resp_data_i,
  input  logic                         resp_v_i,
  output logic                         resp_ready_o
);

  typedef enum logic [2:0] {
    state_idle,
    state_write_req,
    state_read_req,
    state_read_resp,
    state_write_resp
  } state_e;

  state_e    state_r;
  state_e    state_n;
  cmd_word_s write_cmd;
  cmd_word_s read_cmd;

  // No error responses
  assign s_axil_bresp_o = axi_resp_okay_c;
  assign s_axil_rresp_o = axi_resp_okay_c;

  // Read byte goes straight through, zero-extended
  assign s_axil_rdata_o =
    {{(axil_data_width_c - payload_data_width_c){1'b0}}, resp_data_i};
  assign resp_ready_o = s_axil_rready_i;

  assign write_cmd.write_not_read = 1'b1;
  assign write_cmd.addr           = s_axil_awaddr_i[payload_addr_width_c-1:0];
  assign write_cmd.data           = s_axil_wdata_i[payload_data_width_c-1:0];

  assign read_cmd.write_not_read = 1'b0;
  assign read_cmd.addr           = s_axil_araddr_i[payload_addr_width_c-1:0];
  assign read_cmd.data           = '0;

  always_comb
  begin
    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_arready_o = 1'b0;
    s_axil_bvalid_o  = 1'b0;
    s_axil_rvalid_o  = 1'b0;
    cmd_o            = '0;
    cmd_v_o          = 1'b0;
    state_n          = state_r;

    case (state_r)
      state_idle:
      begin
        // Write wins when both halves are present
        if (s_axil_awvalid_i && s_axil_wvalid_i)
          state_n = state_write_req;
        else if (s_axil_arvalid_i)
          state_n = state_read_req;
      end

      state_write_req:
      begin
        cmd_v_o          = 1'b1;
        cmd_o            = write_cmd;
        s_axil_awready_o = cmd_ready_i;
        s_axil_wready_o  = cmd_ready_i;
        if (cmd_ready_i)
          state_n = state_write_resp;
      end

      state_read_req:
      begin
        cmd_v_o          = 1'b1;
        cmd_o            = read_cmd;
        s_axil_arready_o = cmd_ready_i;
        if (cmd_ready_i)
          state_n = state_read_resp;
      end

      state_read_resp:
      begin
        s_axil_rvalid_o = resp_v_i;
        if (resp_v_i && s_axil_rready_i)
          state_n = state_idle;
      end

      state_write_resp:
      begin
        s_axil_bvalid_o = 1'b1;
        if (s_axil_bready_i)
          state_n = state_idle;
      end

      default:
      begin
        state_n = state_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= state_idle;
    else
      state_r <= state_n;
  end

  // A stalled command must stay put until the sender takes it
  cmd_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_o && !cmd_ready_i) |=> (cmd_v_o && $stable(cmd_o)))
    else $error("cmd_v_o dropped or cmd_o changed before transfer");

endmodule

// ==== cmd_credit_tx.sv ====
// ==================================================
// Credit-based sender for command words. Accepts a
// word only while credits remain and launches it onto
// the link one cycle later.
// ==================================================
`timescale 1ns/1ps

module cmd_credit_tx
  import axil_link_pkg::*;
#(
  parameter int credits_p = 2
)
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  cmd_word_s cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_o,

  output cmd_word_s link_word_o,
  output logic      link_v_o,
  input  logic      credit_i
);

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic [cnt_width_lp-1:0] credit_cnt_r;
  logic                    accept;
  logic                    link_v_r;
  cmd_word_s               link_word_r;

  assign cmd_ready_o = (credit_cnt_r != '0);
  assign accept      = cmd_v_i & cmd_ready_o;

  assign link_word_o = link_word_r;
  assign link_v_o    = link_v_r;

  // Returned credit and a launch in the same cycle cancel out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      credit_cnt_r <= cnt_width_lp'(credits_p);
      link_v_r     <= 1'b0;
    end
    else
    begin
      link_v_r <= accept;
      if (credit_i && !accept)
        credit_cnt_r <= credit_cnt_r + 1'b1;
      else if (!credit_i && accept)
        credit_cnt_r <= credit_cnt_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      link_word_r <= cmd_i;
  end

  // Target must never hand back more credits than it owns
  credit_max_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt_r <= cnt_width_lp'(credits_p))
    else $error("credit count above credits_p");

endmodule

// ==== cmd_reg_target.sv ====
// ==================================================
// Far end of the link. Queues incoming command words,
// applies writes to a byte register memory and holds
// read data in a response register until taken.
// ==================================================
`timescale 1ns/1ps

module cmd_reg_target
  import axil_link_pkg::*;
#(
  parameter int credits_p   = 2,
  parameter int mem_words_p = 16
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  cmd_word_s                       link_word_i,
  input  logic                            link_v_i,
  output logic                            credit_o,

  output logic [payload_data_width_c-1:0] resp_data_o,
  output logic                            resp_v_o,
  input  logic                            resp_ready_i
);

  localparam int ptr_width_lp = (credits_p > 1) ? $clog2(credits_p) : 1;
  localparam int cnt_width_lp = $clog2(credits_p + 1);
  localparam int mem_addr_width_lp = $clog2(mem_words_p);

  cmd_word_s                       queue_r [credits_p];
  logic [ptr_width_lp-1:0]         wr_ptr_r;
  logic [ptr_width_lp-1:0]         rd_ptr_r;
  logic [cnt_width_lp-1:0]         count_r;
  logic [payload_data_width_c-1:0] mem_r [mem_words_p];
  logic [payload_data_width_c-1:0] resp_data_r;
  logic                            resp_v_r;

  cmd_word_s                    head;
  logic [mem_addr_width_lp-1:0] head_idx;
  logic                         pop;

  assign head     = queue_r[rd_ptr_r];
  assign head_idx = head.addr[mem_addr_width_lp-1:0];

  // Reads wait for an empty response register, writes never stall
  assign pop = (count_r != '0) && (head.write_not_read || !resp_v_r);

  assign credit_o    = pop;
  assign resp_data_o = resp_data_r;
  assign resp_v_o    = resp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (link_v_i)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(credits_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(credits_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      if (link_v_i && !pop)
        count_r <= count_r + 1'b1;
      else if (!link_v_i && pop)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (link_v_i)
      queue_r[wr_ptr_r] <= link_word_i;
  end

  // Register memory, cleared on reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < mem_words_p; i++)
        mem_r[i] <= '0;
    end
    else if (pop && head.write_not_read)
      mem_r[head_idx] <= head.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (pop && !head.write_not_read)
      resp_v_r <= 1'b1;
    else if (resp_v_r && resp_ready_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (pop && !head.write_not_read)
      resp_data_r <= mem_r[head_idx];
  end

  // Sender credit accounting keeps the queue from overflowing
  queue_overflow_a: assert property (@(posedge clk_i) disable iff (reset_i)
    link_v_i |-> (count_r != cnt_width_lp'(credits_p)))
    else $error("link word arrived while command queue full");

endmodule

// ==== axil_store_link_top.sv ====
// ==================================================
// Top level of the AXI4-Lite register link. Wires the
// packer, the credit sender and the register target
// and passes the queue and memory sizes down.
// ==================================================
`timescale 1ns/1ps

module axil_store_link_top
  import axil_link_pkg::*;
#(
  parameter int credits_p   = 2,
  parameter int mem_words_p = 16
)
(
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic [axil_addr_width_c-1:0] s_axil_awaddr_i,
  input  logic                         s_axil_awvalid_i,
  output logic                         s_axil_awready_o,

  input  logic [axil_data_width_c-1:0] s_axil_wdata_i,
  input  logic                         s_axil_wvalid_i,
  output logic                         s_axil_wready_o,

  output logic [1:0]                   s_axil_bresp_o,
  output logic                         s_axil_bvalid_o,
  input  logic                         s_axil_bready_i,

  input  logic [axil_addr_width_c-1:0] s_axil_araddr_i,
  input  logic                         s_axil_arvalid_i,
  output logic                         s_axil_arready_o,

  output logic [axil_data_width_c-1:0] s_axil_rdata_o,
  output logic [1:0]                   s_axil_rresp_o,
  output logic                         s_axil_rvalid_o,
  input  logic                         s_axil_rready_i
);

  cmd_word_s                       cmd;
  logic                            cmd_v;
  logic                            cmd_ready;
  cmd_word_s                       link_word;
  logic                            link_v;
  logic                            credit;
  logic [payload_data_width_c-1:0] resp_data;
  logic                            resp_v;
  logic                            resp_ready;

  axil_store_packer axil_store_packer_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .cmd_o            (cmd),
    .cmd_v_o          (cmd_v),
    .cmd_ready_i      (cmd_ready),
    .resp_data_i      (resp_data),
    .resp_v_i         (resp_v),
    .resp_ready_o     (resp_ready)
  );

  cmd_credit_tx #(
    .credits_p (credits_p)
  ) cmd_credit_tx_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (cmd),
    .cmd_v_i     (cmd_v),
    .cmd_ready_o (cmd_ready),
    .link_word_o (link_word),
    .link_v_o    (link_v),
    .credit_i    (credit)
  );

  cmd_reg_target #(
    .credits_p   (credits_p),
    .mem_words_p (mem_words_p)
  ) cmd_reg_target_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_word_i  (link_word),
    .link_v_i     (link_v),
    .credit_o     (credit),
    .resp_data_o  (resp_data),
    .resp_v_o     (resp_v),
    .resp_ready_i (resp_ready)
  );

endmodule

// ==== axil_store_link_tb.sv ====
// ==================================================
// Directed testbench for the AXI4-Lite register link.
// Acts as the AXI master and checks every response
// against a byte register model kept here.
// ==================================================
`timescale 1ns/1ps

module axil_store_link_tb
  import axil_link_pkg::*;
();

  localparam int timeout_cycles_c = 200;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer      seed;
  int          error_count;
  int          check_count;
  logic        backpressure_on;
  // Register (address mod 16) holds the low byte of the last write
  logic [7:0]  model [16];

  axil_store_link_top #(
    .credits_p   (2),
    .mem_words_p (16)
  ) axil_store_link_top_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("Timed out at %0t waiting for %s", $time, what);
    finish_run();
  endtask

  // Random stall of the response ready, only in the back-pressure test
  task automatic hold_ready_low();
    int n;
    n = backpressure_on ? int'({$random(seed)} % 16) : 0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_write_accept(input logic check_no_read);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!(awready && wready))
    begin
      if (check_no_read)
        check_value("arready", 32'(1'b0), 32'(arready));
      cycles++;
      if (cycles > timeout_cycles_c)
        report_timeout("awready and wready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic wait_read_accept();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!arready)
    begin
      cycles++;
      if (cycles > timeout_cycles_c)
        report_timeout("arready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    arvalid <= 1'b0;
  endtask

  task automatic take_write_response();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!bvalid)
    begin
      cycles++;
      if (cycles > timeout_cycles_c)
        report_timeout("bvalid");
      @(negedge clk_i);
    end
    hold_ready_low();
    @(posedge clk_i);
    bready <= 1'b1;
    @(negedge clk_i);
    check_value("bvalid", 32'(1'b1), 32'(bvalid));
    check_value("bresp", 32'(axi_resp_okay_c), 32'(bresp));
    @(posedge clk_i);
    bready <= 1'b0;
    // A second response here would be a duplicate
    @(negedge clk_i);
    check_value("bvalid after handshake", 32'(1'b0), 32'(bvalid));
  endtask

  task automatic take_read_response(input logic [7:0] expected);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!rvalid)
    begin
      cycles++;
      if (cycles > timeout_cycles_c)
        report_timeout("rvalid");
      @(negedge clk_i);
    end
    hold_ready_low();
    @(posedge clk_i);
    rready <= 1'b1;
    @(negedge clk_i);
    check_value("rvalid", 32'(1'b1), 32'(rvalid));
    check_value("rdata", 32'(expected), rdata);
    check_value("rresp", 32'(axi_resp_okay_c), 32'(rresp));
    @(posedge clk_i);
    rready <= 1'b0;
    @(negedge clk_i);
    check_value("rvalid after handshake", 32'(1'b0), 32'(rvalid));
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    wait_write_accept(1'b0);
    take_write_response();
    model[addr[3:0]] = data[7:0];
  endtask

  task automatic axil_read(input logic [31:0] addr);
    @(posedge clk_i);
    araddr  <= addr;
    arvalid <= 1'b1;
    wait_read_accept();
    take_read_response(model[addr[3:0]]);
  endtask

  task automatic test_reset_state();
    for (int i = 0; i < 16; i++)
      axil_read(32'(i));
  endtask

  task automatic test_write_read_back();
    logic [31:0] tmp;
    logic [3:0]  stride;
    logic [3:0]  offset;
    logic [3:0]  idx;
    for (int i = 0; i < 16; i++)
      axil_write(32'(i), $random(seed));
    // Odd stride over 16 slots visits each register once
    tmp    = $random(seed);
    stride = tmp[3:0] | 4'd1;
    offset = tmp[7:4];
    for (int k = 0; k < 16; k++)
    begin
      idx = stride * 4'(k) + offset;
      axil_read(32'(idx));
    end
  endtask

  task automatic test_truncation_alias();
    axil_write(32'd3, 32'ha5c3_5a7e);
    axil_read(32'd3);
    axil_write(32'd19, 32'h1234_00f1);
    axil_read(32'd3);
    axil_read(32'd19);
  endtask

  task automatic test_write_priority();
    logic [31:0] data;
    data = $random(seed);
    @(posedge clk_i);
    awaddr  <= 32'd5;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    araddr  <= 32'd5;
    arvalid <= 1'b1;
    wait_write_accept(1'b1);
    take_write_response();
    model[5] = data[7:0];
    wait_read_accept();
    take_read_response(model[5]);
  endtask

  task automatic test_back_pressure();
    logic [31:0] tmp;
    backpressure_on = 1'b1;
    for (int n = 0; n < 24; n++)
    begin
      tmp = $random(seed);
      if (tmp[8])
        axil_write(32'(tmp[5:0]), $random(seed));
      else
        axil_read(32'(tmp[5:0]));
    end
    backpressure_on = 1'b0;
  endtask

  initial
  begin
    seed            = 30;
    error_count     = 0;
    check_count     = 0;
    backpressure_on = 1'b0;
    model           = '{default: 8'h00};
    reset_i         = 1'b1;
    awaddr          = '0;
    awvalid         = 1'b0;
    wdata           = '0;
    wvalid          = 1'b0;
    bready          = 1'b0;
    araddr          = '0;
    arvalid         = 1'b0;
    rready          = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_state();
    test_write_read_back();
    test_truncation_alias();
    test_write_priority();
    test_back_pressure();
    finish_run();
  end

endmodule

// ==== axil_store_link_top.f ====
axil_link_pkg.sv
axil_store_packer.sv
cmd_credit_tx.sv
cmd_reg_target.sv
axil_store_link_top.sv
axil_store_link_tb.sv

// ==== Makefile ====
TOP := axil_store_link_tb

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f axil_store_link_top.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f axil_store_link_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
